// ==== run_sim.sh ====
#!/bin/sh
# build the VGA testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module vga_video_tb \
  -f vga_video.f -o vga_video_sim &&
./obj_dir/vga_video_sim > sim.log 2>&1 &&
! grep -q "Simulation failed" sim.log &&
echo "PASS: see sim.log" ||
{
  echo "FAIL: see sim.log"
  exit 1
}

// ==== vga_output_stage.sv ====
module vga_output_stage (
  input  logic                    pixel_clk_in,
  input  logic                    reset,
  input  vga_timing_pkg::raster_t raster_in,
  input  vga_pixel_pkg::rgb_t     color_in,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    blank,
  output vga_pixel_pkg::rgb_t     color
);

  vga_pixel_pkg::rgb_t masked_color; // zero outside active area

  // DAC must see black during porches and sync
  assign masked_color = raster_in.blank ? '0 : color_in;

  // all pad signals leave from the same edge
  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      hsync <= 1'b1;  // inactive
      vsync <= 1'b1;  // inactive
      blank <= 1'b1;
      color <= '0;
    end else begin
      hsync <= raster_in.hsync_n;
      vsync <= raster_in.vsync_n;
      blank <= raster_in.blank;
      color <= masked_color;
    end
  end

endmodule

// ==== vga_pattern_gen.sv ====
`include "vga_video_consts.svh"

module vga_pattern_gen (
  input  logic                          pixel_clk_in,
  input  logic                          reset,
  input  vga_timing_pkg::raster_t       raster_in,
  input  vga_pixel_pkg::pattern_mode_t  mode,
  input  vga_pixel_pkg::rgb_t           solid_color,
  output vga_timing_pkg::raster_t       raster_out,
  output vga_pixel_pkg::rgb_t           color
);

  localparam vga_timing_pkg::count_t bar_w =
    vga_timing_pkg::count_t'(`VGA_BAR_W);
  localparam vga_timing_pkg::count_t grid_step =
    vga_timing_pkg::count_t'(`VGA_GRID_STEP);
  localparam vga_pixel_pkg::channel_t full = '1;  // channel fully on
  localparam vga_pixel_pkg::rgb_t white = '1;

  // idle raster, shown until the first real pixel arrives
  localparam vga_timing_pkg::raster_t idle_raster = '{
    hcount:  '0,
    vcount:  '0,
    hsync_n: 1'b1,
    vsync_n: 1'b1,
    blank:   1'b1
  };

  logic                         frame_start; // raster_in at (0, 0)
  vga_pixel_pkg::pattern_mode_t mode_q;      // mode for current frame
  vga_pixel_pkg::pattern_mode_t cur_mode;
  vga_pixel_pkg::rgb_t          solid_q;     // colour for current frame
  vga_pixel_pkg::rgb_t          cur_solid;
  logic [2:0]                   bar_idx;     // 0..7 across the active width
  logic [2:0]                   bar_val;
  logic                         checker_on;
  logic                         grid_on;
  vga_pixel_pkg::rgb_t          next_color;

  assign frame_start = (raster_in.hcount == '0) && (raster_in.vcount == '0);

  // pixel (0, 0) already belongs to the new frame
  assign cur_mode  = frame_start ? mode : mode_q;
  assign cur_solid = frame_start ? solid_color : solid_q;

  assign bar_idx = 3'(raster_in.hcount / bar_w);
  assign bar_val = 3'd7 - bar_idx; // white first, black last

  assign checker_on = raster_in.hcount[`VGA_CHECK_SHIFT] ^ raster_in.vcount[`VGA_CHECK_SHIFT];

  assign grid_on = ((raster_in.hcount % grid_step) == '0) ||
                   ((raster_in.vcount % grid_step) == '0);

  always_comb begin
    next_color = '0;
    case (cur_mode)
      vga_pixel_pkg::pat_bars: begin
        next_color.red   = bar_val[2] ? full : '0;
        next_color.green = bar_val[1] ? full : '0;
        next_color.blue  = bar_val[0] ? full : '0;
      end
      vga_pixel_pkg::pat_checker: next_color = checker_on ? white : '0;
      vga_pixel_pkg::pat_grid:    next_color = grid_on ? white : '0;
      vga_pixel_pkg::pat_solid:   next_color = cur_solid;
      default:                    next_color = '0;
    endcase
  end

  // control path
  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      mode_q     <= vga_pixel_pkg::pat_bars;
      raster_out <= idle_raster;
    end else begin
      if (frame_start) begin
        mode_q <= mode; // held for the whole frame
      end
      raster_out <= raster_in; // one cycle delay
    end
  end

  // payload, blanked pixels are coloured too
  always_ff @(posedge pixel_clk_in) begin
    if (frame_start) begin
      solid_q <= solid_color;
    end
    color <= next_color;
  end

endmodule

// ==== vga_pixel_pkg.sv ====
`include "vga_video_consts.svh"

package vga_pixel_pkg;

  typedef logic [`VGA_COLOR_W-1:0] channel_t; // one colour channel

  // 12-bit pixel, red in the top nibble
  typedef struct packed {
    channel_t red;
    channel_t green;
    channel_t blue;
  } rgb_t;

  // test pattern selection
  typedef enum logic [1:0] {
    pat_bars    = 2'd0, // eight vertical colour bars
    pat_checker = 2'd1, // 32x32 checkerboard
    pat_grid    = 2'd2, // white lines every 50 pixels
    pat_solid   = 2'd3  // flat solid_color
  } pattern_mode_t;

endpackage

// ==== vga_timing_gen.sv ====
`include "vga_video_consts.svh"

module vga_timing_gen (
  input  logic                    pixel_clk_in,
  input  logic                    reset,
  output vga_timing_pkg::raster_t raster
);

  // compare points, each one cycle ahead of the edge it causes
  localparam vga_timing_pkg::count_t h_blank_at =
    vga_timing_pkg::count_t'(`VGA_H_ACTIVE - 1);                         // 799
  localparam vga_timing_pkg::count_t h_sync_on_at =
    vga_timing_pkg::count_t'(`VGA_H_ACTIVE + `VGA_H_FP - 1);             // 839
  localparam vga_timing_pkg::count_t h_sync_off_at =
    vga_timing_pkg::count_t'(`VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC - 1); // 967
  localparam vga_timing_pkg::count_t h_last =
    vga_timing_pkg::count_t'(`VGA_H_TOTAL - 1);                          // 1055

  localparam vga_timing_pkg::count_t v_blank_at =
    vga_timing_pkg::count_t'(`VGA_V_ACTIVE - 1);                         // 599
  localparam vga_timing_pkg::count_t v_sync_on_at =
    vga_timing_pkg::count_t'(`VGA_V_ACTIVE + `VGA_V_FP - 1);             // 600
  localparam vga_timing_pkg::count_t v_sync_off_at =
    vga_timing_pkg::count_t'(`VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC - 1); // 604
  localparam vga_timing_pkg::count_t v_last =
    vga_timing_pkg::count_t'(`VGA_V_TOTAL - 1);                          // 627

  logic hblank;      // inside horizontal blanking
  logic vblank;      // inside vertical blanking
  logic h_blank_on;
  logic h_sync_on;
  logic h_sync_off;
  logic h_end;       // last pixel of line
  logic v_blank_on;
  logic v_sync_on;
  logic v_sync_off;
  logic v_end;       // last pixel of frame
  logic next_hblank;
  logic next_vblank;

  assign h_blank_on = (raster.hcount == h_blank_at);
  assign h_sync_on  = (raster.hcount == h_sync_on_at);
  assign h_sync_off = (raster.hcount == h_sync_off_at);
  assign h_end      = (raster.hcount == h_last);

  // vertical events only fire at the end of a line
  assign v_blank_on = h_end & (raster.vcount == v_blank_at);
  assign v_sync_on  = h_end & (raster.vcount == v_sync_on_at);
  assign v_sync_off = h_end & (raster.vcount == v_sync_off_at);
  assign v_end      = h_end & (raster.vcount == v_last);

  assign next_hblank = h_end ? 1'b0 : (h_blank_on ? 1'b1 : hblank);
  assign next_vblank = v_end ? 1'b0 : (v_blank_on ? 1'b1 : vblank);

  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      raster.hcount  <= '0;   // hold at (0, 0)
      raster.vcount  <= '0;
      raster.hsync_n <= 1'b1;
      raster.vsync_n <= 1'b1;
      raster.blank   <= 1'b0; // (0, 0) is active
      hblank         <= 1'b0;
      vblank         <= 1'b0;
    end else begin
      raster.hcount  <= h_end ? '0 : raster.hcount + 1'b1;
      raster.vcount  <= h_end ? (v_end ? '0 : raster.vcount + 1'b1) : raster.vcount;
      raster.hsync_n <= h_sync_on ? 1'b0 : (h_sync_off ? 1'b1 : raster.hsync_n);
      raster.vsync_n <= v_sync_on ? 1'b0 : (v_sync_off ? 1'b1 : raster.vsync_n);
      raster.blank   <= next_hblank | next_vblank; // same cycle as position
      hblank         <= next_hblank;
      vblank         <= next_vblank;
    end
  end

endmodule

// ==== vga_timing_pkg.sv ====
`include "vga_video_consts.svh"

package vga_timing_pkg;

  // one raster coordinate, sized for the larger of the two totals
  typedef logic [`VGA_COUNT_W-1:0] count_t;

  // per-pixel timing as it moves down the pipeline
  typedef struct packed {
    count_t hcount;  // pixel within line
    count_t vcount;  // line within frame
    logic   hsync_n; // active low
    logic   vsync_n; // active low
    logic   blank;   // high outside active area
  } raster_t;

endpackage

// ==== vga_video.f ====
+incdir+.
vga_timing_pkg.sv
vga_pixel_pkg.sv
vga_timing_gen.sv
vga_pattern_gen.sv
vga_output_stage.sv
vga_video_top.sv
vga_video_checker.sv
vga_video_tb.sv

// ==== vga_video_checker.sv ====
`include "vga_video_consts.svh"

module vga_video_checker (
  input logic                pixel_clk_in,
  input logic                reset,
  input logic                hsync,
  input logic                vsync,
  input logic                blank,
  input vga_pixel_pkg::rgb_t color
);

  logic [15:0] hs_low_run;  // cycles hsync has been low
  logic [15:0] hs_high_run; // cycles since hsync came back up
  logic [15:0] vs_low_run;  // cycles vsync has been low

  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      hs_low_run  <= '0;
      hs_high_run <= '0;
      vs_low_run  <= '0;
    end else begin
      hs_low_run  <= hsync ? '0 : hs_low_run + 16'd1;
      hs_high_run <= hsync ? hs_high_run + 16'd1 : '0;
      vs_low_run  <= vsync ? '0 : vs_low_run + 16'd1;
    end
  end

  blank_is_black: assert property (@(posedge pixel_clk_in) disable iff (reset)
    blank |-> (color == '0))
    else $error("color not zero while blank is high");

  hsync_width: assert property (@(posedge pixel_clk_in) disable iff (reset)
    $rose(hsync) |-> (hs_low_run == 16'(`VGA_H_SYNC)))
    else $error("hsync low pulse has the wrong length");

  vsync_width: assert property (@(posedge pixel_clk_in) disable iff (reset)
    $rose(vsync) |-> (vs_low_run == 16'(`VGA_V_SYNC * `VGA_H_TOTAL)))
    else $error("vsync low pulse is not four lines");

  // line start sits one back porch after hsync rises
  vsync_on_line_start: assert property (@(posedge pixel_clk_in) disable iff (reset)
    (vsync != $past(vsync)) |-> (hsync && hs_high_run == 16'(`VGA_H_BP)))
    else $error("vsync changed away from a line start");

endmodule

bind vga_video_top vga_video_checker u_checker (
  .pixel_clk_in (pixel_clk_in),
  .reset        (reset),
  .hsync        (hsync),
  .vsync        (vsync),
  .blank        (blank),
  .color        (color)
);

// ==== vga_video_consts.svh ====
`ifndef VGA_VIDEO_CONSTS_SVH
`define VGA_VIDEO_CONSTS_SVH

// 800x600 at 60 Hz, 40 MHz pixel clock

`define VGA_H_ACTIVE    800   // visible pixels per line
`define VGA_H_FP        40    // horizontal front porch
`define VGA_H_SYNC      128   // hsync pulse width
`define VGA_H_BP        88    // horizontal back porch
`define VGA_H_TOTAL     (`VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC + `VGA_H_BP)  // 1056

`define VGA_V_ACTIVE    600   // visible lines per frame
`define VGA_V_FP        1     // vertical front porch, lines
`define VGA_V_SYNC      4     // vsync pulse, lines
`define VGA_V_BP        23    // vertical back porch, lines
`define VGA_V_TOTAL     (`VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC + `VGA_V_BP)  // 628

`define VGA_COUNT_W     11    // wide enough for 1056
`define VGA_COLOR_W     4     // bits per channel

// test pattern geometry
`define VGA_BAR_W       100   // eight bars across 800
`define VGA_CHECK_SHIFT 5     // 32 pixel squares
`define VGA_GRID_STEP   50    // grid line pitch

`endif

// ==== vga_video_tb.sv ====
`include "vga_video_consts.svh"

module vga_video_tb;

  localparam int frame_cycles = `VGA_H_TOTAL * `VGA_V_TOTAL;  // 663168
  localparam int run_frames   = 4;                              // one per pattern
  localparam longint watchdog_limit = longint'(frame_cycles) * 5 * 100; // five frames
  localparam int h_sync_start = `VGA_H_ACTIVE + `VGA_H_FP;      // 840
  localparam int h_sync_end   = h_sync_start + `VGA_H_SYNC;     // 968, exclusive
  localparam int v_sync_start = `VGA_V_ACTIVE + `VGA_V_FP;      // 601
  localparam int v_sync_end   = v_sync_start + `VGA_V_SYNC;     // 605, exclusive
  localparam int force_line   = `VGA_V_TOTAL - 18;              // next frame's mode held from here

  logic                         pixel_clk_in;
  logic                         reset;
  vga_pixel_pkg::pattern_mode_t mode;
  vga_pixel_pkg::rgb_t          solid_color;
  logic                         hsync;
  logic                         vsync;
  logic                         blank;
  vga_pixel_pkg::rgb_t          color;

  vga_pixel_pkg::pattern_mode_t frame_order [run_frames]; // pattern per frame
  vga_pixel_pkg::pattern_mode_t mode_prev;   // driven one falling edge earlier
  vga_pixel_pkg::rgb_t          solid_prev;
  vga_pixel_pkg::pattern_mode_t lat_mode;    // model frame latch
  vga_pixel_pkg::rgb_t          lat_solid;
  int                           oh;          // model position on the pads
  int                           ov;
  int                           frame_no;    // -1 until the first frame

  vga_video_top uut (
    .pixel_clk_in (pixel_clk_in),
    .reset        (reset),
    .mode         (mode),
    .solid_color  (solid_color),
    .hsync        (hsync),
    .vsync        (vsync),
    .blank        (blank),
    .color        (color)
  );

  initial begin
    pixel_clk_in = 1'b0;
    forever #50 pixel_clk_in = ~pixel_clk_in; // 100 unit period
  end

  initial begin
    #(watchdog_limit);
    $display("TIMEOUT: the run did not finish within five frame times");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s at pixel (%0d, %0d) frame %0d: expected 'h%0h, actual 'h%0h",
               name, oh, ov, frame_no, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // pads in their reset state
  task automatic confirm_idle(input string phase);
    check_value({phase, " hsync"}, 32'd1, 32'(hsync));
    check_value({phase, " vsync"}, 32'd1, 32'(vsync));
    check_value({phase, " blank"}, 32'd1, 32'(blank));
    check_value({phase, " color"}, 32'd0, 32'(color));
  endtask

  // colour rules for one screen position
  function automatic vga_pixel_pkg::rgb_t model_color(input int h, input int v,
                                                      input vga_pixel_pkg::pattern_mode_t m,
                                                      input vga_pixel_pkg::rgb_t s);
    int                  bar_val;
    vga_pixel_pkg::rgb_t c;
    c = '0;
    if (h >= `VGA_H_ACTIVE || v >= `VGA_V_ACTIVE) begin
      return c;                                 // blanked, always black
    end
    case (m)
      vga_pixel_pkg::pat_bars: begin
        bar_val = 7 - (h / `VGA_BAR_W);         // white first
        c.red   = ((bar_val >> 2) & 1) != 0 ? 4'hf : 4'h0;
        c.green = ((bar_val >> 1) & 1) != 0 ? 4'hf : 4'h0;
        c.blue  = (bar_val & 1) != 0 ? 4'hf : 4'h0;
      end
      vga_pixel_pkg::pat_checker: begin
        if (((h >> `VGA_CHECK_SHIFT) & 1) != ((v >> `VGA_CHECK_SHIFT) & 1)) begin
          c = 12'hfff;
        end
      end
      vga_pixel_pkg::pat_grid: begin
        if ((h % `VGA_GRID_STEP) == 0 || (v % `VGA_GRID_STEP) == 0) begin
          c = 12'hfff;
        end
      end
      default: c = s;                           // solid
    endcase
    return c;
  endfunction

  task automatic compare_pixel();
    vga_pixel_pkg::rgb_t exp_color;
    logic                exp_hsync;
    logic                exp_vsync;
    logic                exp_blank;
    if (oh == 0 && ov == 0) begin
      lat_mode       = mode_prev;  // what the DUT sampled at the frame start
      lat_solid      = solid_prev;
      frame_no       = frame_no + 1;
    end
    exp_hsync = !(oh >= h_sync_start && oh < h_sync_end);
    exp_vsync = !(ov >= v_sync_start && ov < v_sync_end);  // whole lines
    exp_blank = (oh >= `VGA_H_ACTIVE) || (ov >= `VGA_V_ACTIVE);
    exp_color = model_color(oh, ov, lat_mode, lat_solid);
    check_value("hsync", 32'(exp_hsync), 32'(hsync));
    check_value("vsync", 32'(exp_vsync), 32'(vsync));
    check_value("blank", 32'(exp_blank), 32'(blank));
    check_value("color", 32'(exp_color), 32'(color));
  endtask

  task automatic step_position();
    oh = oh + 1;
    if (oh == `VGA_H_TOTAL) begin
      oh = 0;
      ov = (ov == `VGA_V_TOTAL - 1) ? 0 : ov + 1;  // frame wrap
    end
  endtask

  task automatic drive_inputs();
    mode_prev  = mode;
    solid_prev = solid_color;
    if (frame_no < 0 || (ov >= force_line && frame_no < run_frames - 1)) begin
      mode = frame_order[frame_no + 1];  // value the next frame must pick up
    end else if ($urandom_range(0, 4095) == 0) begin
      mode = vga_pixel_pkg::pattern_mode_t'($urandom_range(0, 3)); // stray change
    end
    if ($urandom_range(0, 4095) == 0) begin
      solid_color = vga_pixel_pkg::rgb_t'(12'($urandom));  // any time, even mid-frame
    end
  endtask

  // random frame order, each pattern once
  task automatic shuffle_modes();
    int                           j;
    vga_pixel_pkg::pattern_mode_t tmp;
    frame_order[0] = vga_pixel_pkg::pat_bars;
    frame_order[1] = vga_pixel_pkg::pat_checker;
    frame_order[2] = vga_pixel_pkg::pat_grid;
    frame_order[3] = vga_pixel_pkg::pat_solid;
    for (int i = run_frames - 1; i > 0; i--) begin
      j              = int'($urandom_range(0, i));
      tmp            = frame_order[i];
      frame_order[i] = frame_order[j];
      frame_order[j] = tmp;
    end
  endtask

  initial begin
    void'($urandom(32'h32a6));
    reset       = 1'b1;
    solid_color = '0;
    oh          = 0;
    ov          = 0;
    frame_no    = -1;
    shuffle_modes();
    mode        = frame_order[0];
    mode_prev   = mode;
    solid_prev  = solid_color;
    lat_mode    = mode;
    lat_solid   = solid_color;
    repeat (5) begin                 // five rising edges in reset
      @(negedge pixel_clk_in);
      confirm_idle("reset");
      drive_inputs();
    end
    reset = 1'b0;
    @(negedge pixel_clk_in);
    confirm_idle("first edge after reset"); // pipeline still filling
    drive_inputs();
    for (int n = 0; n < run_frames * frame_cycles; n++) begin
      @(negedge pixel_clk_in);
      compare_pixel();
      step_position();
      drive_inputs();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== vga_video_top.sv ====
module vga_video_top (
  input  logic                          pixel_clk_in,
  input  logic                          reset,
  input  vga_pixel_pkg::pattern_mode_t  mode,
  input  vga_pixel_pkg::rgb_t           solid_color,
  output logic                          hsync,
  output logic                          vsync,
  output logic                          blank,
  output vga_pixel_pkg::rgb_t           color
);

  vga_timing_pkg::raster_t timing_raster;  // stage 0, from the counters
  vga_timing_pkg::raster_t pattern_raster; // stage 1, aligned with pattern_color
  vga_pixel_pkg::rgb_t     pattern_color;

  vga_timing_gen u_timing_gen (
    .pixel_clk_in (pixel_clk_in),
    .reset        (reset),
    .raster       (timing_raster)
  );

  vga_pattern_gen u_pattern_gen (
    .pixel_clk_in (pixel_clk_in),
    .reset        (reset),
    .raster_in    (timing_raster),
    .mode         (mode),
    .solid_color  (solid_color),
    .raster_out   (pattern_raster),
    .color        (pattern_color)
  );

  // pads, two cycles behind the counters
  vga_output_stage u_output_stage (
    .pixel_clk_in (pixel_clk_in),
    .reset        (reset),
    .raster_in    (pattern_raster),
    .color_in     (pattern_color),
    .hsync        (hsync),
    .vsync        (vsync),
    .blank        (blank),
    .color        (color)
  );

endmodule
